// ==== include/ilk_defines.svh ====
`ifndef ILK_DEFINES_SVH
`define ILK_DEFINES_SVH

////////////////////////////////////////////////////////////
// word format
////////////////////////////////////////////////////////////

// 64 data bits plus the control flag
`define ILK_WORD_W 65
// words delivered per clock, upper word arrives first
`define ILK_WORDS 2

// control word type bits
`define ILK_CTL_BIT 64
`define ILK_BURST_BIT 63
`define ILK_SOP_BIT 62
// sop field, cleared when the word closes our burst
`define ILK_SOP_FIELD_BIT 61
// eop field, cleared when the word opens our burst
`define ILK_EOP_HI 60
`define ILK_EOP_LO 57
// channel number carried by burst control words
`define ILK_CHAN_HI 39
`define ILK_CHAN_LO 32
`define ILK_CHAN_W (`ILK_CHAN_HI - `ILK_CHAN_LO + 1)

////////////////////////////////////////////////////////////
// buffering, counters and register map
////////////////////////////////////////////////////////////

`define ILK_FIFO_DEPTH 16
`define ILK_CNT_W 32

// wishbone side
`define ILK_ADR_W 2
`define ILK_WB_W 32

// register word addresses
`define ILK_REG_CTRL 2'd0
`define ILK_REG_STATUS 2'd1
`define ILK_REG_WORDS 2'd2
`define ILK_REG_BURSTS 2'd3

// bit positions inside ctrl and status
`define ILK_CTRL_EN_BIT 0
`define ILK_CTRL_CHAN_LO 8
`define ILK_STAT_OVF_BIT 0
`define ILK_STAT_EMPTY_BIT 1

`endif

// ==== logic/ilk_pkg.sv ====
`default_nettype none

`include "ilk_defines.svh"

package ilk_pkg;

	// one link word, bit 64 flags a control word
	typedef logic [`ILK_WORD_W-1:0] ilk_word_t;

	// one cycle of link data
	// index 1 is the upper word and the first arrival
	typedef ilk_word_t [`ILK_WORDS-1:0] ilk_pair_t;

	// register word addresses of the wishbone slave
	typedef enum logic [`ILK_ADR_W-1:0] {
		REG_CTRL   = `ILK_REG_CTRL,
		REG_STATUS = `ILK_REG_STATUS,
		REG_WORDS  = `ILK_REG_WORDS,
		REG_BURSTS = `ILK_REG_BURSTS
	} ilk_reg_e;

endpackage

`default_nettype wire

// ==== logic/ilk_chan_filter.sv ====
`default_nettype none

`include "ilk_defines.svh"

module ilk_chan_filter (
	input  wire logic                    clk,
	input  wire logic                    arst,
	input  wire logic                    in_valid,
	input  wire ilk_pkg::ilk_pair_t      in_words,
	input  wire logic [`ILK_CHAN_W-1:0]  chan_sel,
	input  wire logic                    filt_en,
	output logic [1:0]                   num_valid,
	output ilk_pkg::ilk_pair_t           chan_words
);
	import ilk_pkg::*;

	// clear the sop field of a word that closes our burst
	function automatic ilk_word_t clear_sop(input ilk_word_t w);
		ilk_word_t r;
		r = w;
		r[`ILK_SOP_FIELD_BIT] = 1'b0;
		return r;
	endfunction

	// clear the eop field of a word that opens our burst
	function automatic ilk_word_t clear_eop(input ilk_word_t w);
		ilk_word_t r;
		r = w;
		r[`ILK_EOP_HI:`ILK_EOP_LO] = '0;
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// stage 1, input capture
	////////////////////////////////////////////////////////////

	ilk_pair_t s1_words;
	logic      s1_valid;

	// a disabled filter simply sees no valid input
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid & filt_en;
		end
	end

	always_ff @(posedge clk) begin
		s1_words <= in_words;
	end

	////////////////////////////////////////////////////////////
	// stage 2, classify each word as start or stop
	////////////////////////////////////////////////////////////

	logic [`ILK_WORDS-1:0] is_start;
	logic [`ILK_WORDS-1:0] is_stop;

	always_comb begin
		logic eop_info;
		logic chan_info;
		for (int i = 0; i < `ILK_WORDS; i++) begin
			// burst or idle control words carry eop info
			eop_info = s1_words[i][`ILK_CTL_BIT] & s1_words[i][`ILK_BURST_BIT];
			// only burst control words carry channel info
			chan_info = eop_info & s1_words[i][`ILK_SOP_BIT];
			is_start[i] = chan_info &
				(s1_words[i][`ILK_CHAN_HI:`ILK_CHAN_LO] == chan_sel);
			// a start on our own channel continues the burst
			is_stop[i] = eop_info & ~is_start[i];
		end
	end

	ilk_pair_t             s2_words;
	logic                  s2_valid;
	logic [`ILK_WORDS-1:0] s2_start;
	logic [`ILK_WORDS-1:0] s2_stop;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s2_valid <= 1'b0;
			s2_start <= '0;
			s2_stop  <= '0;
		end else begin
			s2_valid <= s1_valid;
			s2_start <= is_start;
			s2_stop  <= is_stop;
		end
	end

	always_ff @(posedge clk) begin
		s2_words <= s1_words;
	end

	////////////////////////////////////////////////////////////
	// stage 3, mark words from start through stop
	////////////////////////////////////////////////////////////

	// burst state left behind by the last valid pair
	logic last_mine;
	logic mine_hi;
	logic mine_lo;
	logic mine_end;
	logic open_hi;
	logic open_lo;

	assign mine_hi  = last_mine | s2_start[1];
	assign mine_lo  = (mine_hi & ~s2_stop[1]) | s2_start[0];
	assign mine_end = mine_lo & ~s2_stop[0];

	// a start seen while the state before it is idle opens the burst
	assign open_hi = s2_start[1] & ~last_mine;
	assign open_lo = s2_start[0] & ~(mine_hi & ~s2_stop[1]);

	ilk_pair_t             s3_words;
	logic [`ILK_WORDS-1:0] s3_mine;
	logic [`ILK_WORDS-1:0] s3_open;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s3_mine   <= '0;
			s3_open   <= '0;
			last_mine <= 1'b0;
		end else begin
			s3_mine <= {mine_hi, mine_lo} & {`ILK_WORDS{s2_valid}};
			s3_open <= {open_hi, open_lo} & {`ILK_WORDS{s2_valid}};
			// idle cycles keep the burst state
			if (s2_valid) begin
				last_mine <= mine_end;
			end
		end
	end

	// sop on a stop word belongs to another channel
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ILK_WORDS; i++) begin
			s3_words[i] <= s2_stop[i] ? clear_sop(s2_words[i]) : s2_words[i];
		end
	end

	////////////////////////////////////////////////////////////
	// stage 4, eop masking on burst openers
	////////////////////////////////////////////////////////////

	ilk_pair_t             s4_words;
	logic [`ILK_WORDS-1:0] s4_mine;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s4_mine <= '0;
		end else begin
			s4_mine <= s3_mine;
		end
	end

	// eop on an opener refers to data of another channel
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ILK_WORDS; i++) begin
			s4_words[i] <= s3_open[i] ? clear_eop(s3_words[i]) : s3_words[i];
		end
	end

	////////////////////////////////////////////////////////////
	// stage 5 and 6, pack marked words upward
	////////////////////////////////////////////////////////////

	ilk_pair_t  s5_words;
	logic [1:0] s5_num;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s5_num <= 2'd0;
		end else begin
			s5_num <= {1'b0, s4_mine[1]} + {1'b0, s4_mine[0]};
		end
	end

	// upper slot takes the first marked word
	always_ff @(posedge clk) begin
		s5_words[1] <= s4_mine[1] ? s4_words[1] : s4_words[0];
		s5_words[0] <= s4_words[0];
	end

	// unused slots leave as zero
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			num_valid  <= 2'd0;
			chan_words <= '0;
		end else begin
			num_valid     <= s5_num;
			chan_words[1] <= (s5_num != 2'd0) ? s5_words[1] : '0;
			chan_words[0] <= (s5_num == 2'd2) ? s5_words[0] : '0;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// a stop must still be a control word after sop masking
	for (genvar gi = 0; gi < `ILK_WORDS; gi++) begin : g_stop_chk
		a_stop_ctl: assert property (@(posedge clk) disable iff (arst)
			s2_valid && s2_stop[gi] |=> s3_words[gi][`ILK_CTL_BIT]);
	end

	// two words per cycle at most
	a_num_range: assert property (@(posedge clk) disable iff (arst)
		num_valid != 2'd3);

endmodule

`default_nettype wire

// ==== logic/ilk_word_fifo.sv ====
`default_nettype none

`include "ilk_defines.svh"

module ilk_word_fifo (
	input  wire logic               clk,
	input  wire logic               arst,
	input  wire logic [1:0]         num_valid,
	input  wire ilk_pkg::ilk_pair_t chan_words,
	input  wire logic               out_ready,
	output logic                    out_valid,
	output ilk_pkg::ilk_word_t      out_word,
	output logic                    empty,
	output logic                    ovf_pulse
);
	import ilk_pkg::*;

	localparam int DEPTH = `ILK_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	ilk_word_t     mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [AW:0]   free;
	logic          fits;
	logic          do_rd;
	logic [1:0]    wr_n;

	// room is judged before this cycle's read
	assign free  = (AW+1)'(DEPTH) - count;
	assign fits  = free >= {{(AW-1){1'b0}}, num_valid};
	// a write that does not fit is dropped whole
	assign wr_n  = fits ? num_valid : 2'd0;
	assign do_rd = out_valid & out_ready;

	// upper word goes in first
	always_ff @(posedge clk) begin
		if (wr_n != 2'd0) begin
			mem[wr_ptr] <= chan_words[1];
		end
		if (wr_n == 2'd2) begin
			mem[wr_ptr + 1'b1] <= chan_words[0];
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			ovf_pulse <= 1'b0;
		end else begin
			wr_ptr    <= wr_ptr + AW'(wr_n);
			rd_ptr    <= rd_ptr + AW'(do_rd);
			count     <= count + (AW+1)'(wr_n) - (AW+1)'(do_rd);
			ovf_pulse <= ~fits;
		end
	end

	// head word stays put until it is taken
	assign out_word  = mem[rd_ptr];
	assign out_valid = (count != '0);
	assign empty     = (count == '0);

	a_count_max: assert property (@(posedge clk) disable iff (arst)
		count <= (AW+1)'(DEPTH));

	// equal pointers below full mean nothing is stored
	a_empty_no_valid: assert property (@(posedge clk) disable iff (arst)
		(wr_ptr == rd_ptr) && (count != (AW+1)'(DEPTH)) |-> !out_valid);

endmodule

`default_nettype wire

// ==== logic/ilk_burst_stats.sv ====
`default_nettype none

`include "ilk_defines.svh"

module ilk_burst_stats (
	input  wire logic                  clk,
	input  wire logic                  arst,
	input  wire logic [1:0]            num_valid,
	input  wire ilk_pkg::ilk_pair_t    chan_words,
	input  wire logic                  cnt_clear_words,
	input  wire logic                  cnt_clear_bursts,
	output logic [`ILK_CNT_W-1:0]      word_cnt,
	output logic [`ILK_CNT_W-1:0]      burst_cnt
);
	import ilk_pkg::*;

	localparam int W = `ILK_CNT_W;

	// add and stick at all ones
	function automatic logic [W-1:0] sat_add(input logic [W-1:0] cnt, input logic [1:0] inc);
		logic [W:0] sum;
		sum = {1'b0, cnt} + (W+1)'(inc);
		return sum[W] ? '1 : sum[W-1:0];
	endfunction

	// burst control word with sop set
	function automatic logic is_burst_start(input ilk_word_t w);
		return w[`ILK_CTL_BIT] & w[`ILK_BURST_BIT] & w[`ILK_SOP_BIT];
	endfunction

	logic [1:0] bs;
	logic [1:0] burst_inc;

	// only slots that num_valid marks are looked at
	assign bs[1] = (num_valid != 2'd0) & is_burst_start(chan_words[1]);
	assign bs[0] = (num_valid == 2'd2) & is_burst_start(chan_words[0]);
	assign burst_inc = {1'b0, bs[1]} + {1'b0, bs[0]};

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			word_cnt  <= '0;
			burst_cnt <= '0;
		end else begin
			// a clear wins over this cycle's count
			word_cnt  <= cnt_clear_words ? '0 : sat_add(word_cnt, num_valid);
			burst_cnt <= cnt_clear_bursts ? '0 : sat_add(burst_cnt, burst_inc);
		end
	end

endmodule

`default_nettype wire

// ==== logic/ilk_rx_ctrl.sv ====
`default_nettype none

`include "ilk_defines.svh"

module ilk_rx_ctrl (
	input  wire logic                   clk,
	input  wire logic                   arst,
	input  wire logic                   wb_cyc,
	input  wire logic                   wb_stb,
	input  wire logic                   wb_we,
	input  wire logic [`ILK_ADR_W-1:0]  wb_adr,
	input  wire logic [`ILK_WB_W-1:0]   wb_dat_w,
	input  wire logic                   ovf_pulse,
	input  wire logic                   empty,
	input  wire logic [`ILK_CNT_W-1:0]  word_cnt,
	input  wire logic [`ILK_CNT_W-1:0]  burst_cnt,
	output logic [`ILK_WB_W-1:0]        wb_dat_r,
	output logic                        wb_ack,
	output logic [`ILK_CHAN_W-1:0]      chan_sel,
	output logic                        filt_en,
	output logic                        cnt_clear_words,
	output logic                        cnt_clear_bursts
);
	import ilk_pkg::*;

	logic                req;
	logic                wr;
	ilk_reg_e            reg_sel;
	logic                ovf_sticky;
	logic [`ILK_WB_W-1:0] rd_data;

	// new access only when no ack is pending
	assign req     = wb_cyc & wb_stb & ~wb_ack;
	assign wr      = req & wb_we;
	assign reg_sel = ilk_reg_e'(wb_adr);

	////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		case (reg_sel)
			REG_CTRL: begin
				rd_data[`ILK_CTRL_EN_BIT] = filt_en;
				rd_data[`ILK_CTRL_CHAN_LO +: `ILK_CHAN_W] = chan_sel;
			end
			REG_STATUS: begin
				rd_data[`ILK_STAT_OVF_BIT]   = ovf_sticky;
				rd_data[`ILK_STAT_EMPTY_BIT] = empty;
			end
			REG_WORDS:  rd_data = word_cnt;
			REG_BURSTS: rd_data = burst_cnt;
			default:    rd_data = '0;
		endcase
	end

	// read data is captured with the ack
	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_data;
		end
	end

	////////////////////////////////////////////////////////////
	// registers and clear pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wb_ack           <= 1'b0;
			filt_en          <= 1'b0;
			chan_sel         <= '0;
			ovf_sticky       <= 1'b0;
			cnt_clear_words  <= 1'b0;
			cnt_clear_bursts <= 1'b0;
		end else begin
			wb_ack <= req;
			if (wr && reg_sel == REG_CTRL) begin
				filt_en  <= wb_dat_w[`ILK_CTRL_EN_BIT];
				chan_sel <= wb_dat_w[`ILK_CTRL_CHAN_LO +: `ILK_CHAN_W];
			end
			// a new overflow beats a clear in the same cycle
			if (ovf_pulse) begin
				ovf_sticky <= 1'b1;
			end else if (wr && reg_sel == REG_STATUS && wb_dat_w[`ILK_STAT_OVF_BIT]) begin
				ovf_sticky <= 1'b0;
			end
			// any write to a counter clears it
			cnt_clear_words  <= wr && (reg_sel == REG_WORDS);
			cnt_clear_bursts <= wr && (reg_sel == REG_BURSTS);
		end
	end

	// classic single cycle ack, never back to back
	a_ack_single: assert property (@(posedge clk) disable iff (arst)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// ==== logic/ilk_rx_chan_top.sv ====
`default_nettype none

`include "ilk_defines.svh"

module ilk_rx_chan_top (
	input  wire logic                   clk,
	input  wire logic                   arst,
	input  wire logic                   in_valid,
	input  wire ilk_pkg::ilk_pair_t     in_words,
	output logic                        out_valid,
	output ilk_pkg::ilk_word_t          out_word,
	input  wire logic                   out_ready,
	input  wire logic                   wb_cyc,
	input  wire logic                   wb_stb,
	input  wire logic                   wb_we,
	input  wire logic [`ILK_ADR_W-1:0]  wb_adr,
	input  wire logic [`ILK_WB_W-1:0]   wb_dat_w,
	output logic [`ILK_WB_W-1:0]        wb_dat_r,
	output logic                        wb_ack
);
	import ilk_pkg::*;

	// control to datapath
	logic [`ILK_CHAN_W-1:0] chan_sel;
	logic                   filt_en;
	logic                   cnt_clear_words;
	logic                   cnt_clear_bursts;

	// filter output, shared by fifo and stats
	logic [1:0]             num_valid;
	ilk_pair_t              chan_words;

	// status back to control
	logic                   ovf_pulse;
	logic                   empty;
	logic [`ILK_CNT_W-1:0]  word_cnt;
	logic [`ILK_CNT_W-1:0]  burst_cnt;

	ilk_rx_ctrl ctrl0 (
		.clk, .arst,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.ovf_pulse, .empty, .word_cnt, .burst_cnt,
		.wb_dat_r, .wb_ack,
		.chan_sel, .filt_en, .cnt_clear_words, .cnt_clear_bursts
	);

	ilk_chan_filter filt0 (
		.clk, .arst, .in_valid, .in_words, .chan_sel, .filt_en,
		.num_valid, .chan_words
	);

	ilk_word_fifo fifo0 (
		.clk, .arst, .num_valid, .chan_words, .out_ready,
		.out_valid, .out_word, .empty, .ovf_pulse
	);

	ilk_burst_stats stats0 (
		.clk, .arst, .num_valid, .chan_words,
		.cnt_clear_words, .cnt_clear_bursts,
		.word_cnt, .burst_cnt
	);

endmodule

`default_nettype wire

// ==== test/tb_ilk_rx_chan.sv ====
`default_nettype none

`include "ilk_defines.svh"

module tb_ilk_rx_chan;
	import ilk_pkg::*;

	localparam int PERIOD      = 10;
	localparam int TBL_N       = 18;
	localparam int CYC_MARGIN  = 10;
	localparam int N_PASSES    = 4;
	localparam int REG_CYCLES  = 600;
	localparam int WATCHDOG_T  = (TBL_N * CYC_MARGIN * N_PASSES + REG_CYCLES) * PERIOD;
	localparam int WB_LIMIT    = 16;
	localparam int DRAIN_LIMIT = TBL_N * 8;
	localparam int RDY_LOW     = 0;
	localparam int RDY_HIGH    = 1;
	localparam int RDY_RAND    = 2;
	// channel 5 in bits 15:8, enable in bit 0
	localparam logic [31:0] CTRL_CH5_ON  = 32'h0000_0501;
	localparam logic [31:0] CTRL_CH5_OFF = 32'h0000_0500;

	logic                  clk = 1'b0;
	logic                  arst;
	logic                  in_valid;
	ilk_pair_t             in_words;
	logic                  out_valid;
	ilk_word_t             out_word;
	logic                  out_ready = 1'b0;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`ILK_ADR_W-1:0] wb_adr;
	logic [`ILK_WB_W-1:0]  wb_dat_w;
	logic [`ILK_WB_W-1:0]  wb_dat_r;
	logic                  wb_ack;

	// stimulus table, one link cycle per entry
	logic      tbl_valid [TBL_N];
	ilk_pair_t tbl_words [TBL_N];

	// expected channel words and counts from the reference model
	ilk_word_t exp_list[$];
	int        exp_words;
	int        exp_bursts;

	// owned by the main process
	int   errors = 0;
	int   ready_mode = RDY_LOW;
	logic check_out = 1'b0;

	// owned by the output monitor
	int          mon_errors = 0;
	int          got_cnt = 0;
	int          valid_cycles = 0;
	ilk_word_t   exp_w;
	logic [31:0] rnd_bits;

	ilk_rx_chan_top dut0 (
		.clk(clk), .arst(arst),
		.in_valid(in_valid), .in_words(in_words),
		.out_valid(out_valid), .out_word(out_word), .out_ready(out_ready),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	always #(PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// word builders and stimulus table
	////////////////////////////////////////////////////////////

	// burst control word with channel info, sop and eop fields filled
	function automatic ilk_word_t start_word(input logic [7:0] chan, input logic [3:0] eop,
			input logic [15:0] tag);
		ilk_word_t w;
		w = '0;
		w[`ILK_CTL_BIT] = 1'b1;
		w[`ILK_BURST_BIT] = 1'b1;
		w[`ILK_SOP_BIT] = 1'b1;
		w[`ILK_SOP_FIELD_BIT] = 1'b1;
		w[`ILK_EOP_HI:`ILK_EOP_LO] = eop;
		w[`ILK_CHAN_HI:`ILK_CHAN_LO] = chan;
		w[15:0] = tag;
		return w;
	endfunction

	// idle or eop-only control word, never carries a channel
	function automatic ilk_word_t idle_word(input logic [3:0] eop, input logic sop);
		ilk_word_t w;
		w = '0;
		w[`ILK_CTL_BIT] = 1'b1;
		w[`ILK_BURST_BIT] = 1'b1;
		w[`ILK_SOP_FIELD_BIT] = sop;
		w[`ILK_EOP_HI:`ILK_EOP_LO] = eop;
		return w;
	endfunction

	function automatic ilk_word_t data_word(input logic [15:0] tag);
		return {1'b0, 16'hda7a, tag, 16'h0000, tag};
	endfunction

	task automatic set_entry(input int idx, input logic v, input ilk_word_t hi,
			input ilk_word_t lo);
		tbl_valid[idx] = v;
		tbl_words[idx][1] = hi;
		tbl_words[idx][0] = lo;
	endtask

	task automatic build_table();
		set_entry(0, 1'b1, idle_word(4'h0, 1'b0), idle_word(4'h0, 1'b0));
		// channel 5 burst opened from idle
		set_entry(1, 1'b1, start_word(8'd5, 4'h3, 16'h0001), data_word(16'h0001));
		set_entry(2, 1'b1, data_word(16'h0002), data_word(16'h0003));
		// gap, the content must be ignored
		set_entry(3, 1'b0, data_word(16'h0063), start_word(8'd5, 4'h1, 16'h0063));
		// same channel start continues the burst
		set_entry(4, 1'b1, start_word(8'd5, 4'h9, 16'h0004), data_word(16'h0004));
		set_entry(5, 1'b1, data_word(16'h0005), idle_word(4'h2, 1'b1));
		// channel 3 traffic, not ours
		set_entry(6, 1'b1, start_word(8'd3, 4'h1, 16'h0006), data_word(16'h0006));
		set_entry(7, 1'b1, data_word(16'h0007), data_word(16'h0008));
		// channel 5 closed by a switch to channel 3
		set_entry(8, 1'b1, start_word(8'd5, 4'h6, 16'h0009), data_word(16'h0009));
		set_entry(9, 1'b1, data_word(16'h000a), start_word(8'd3, 4'h5, 16'h000a));
		set_entry(10, 1'b1, data_word(16'h000b), data_word(16'h000c));
		set_entry(11, 1'b0, data_word(16'h0064), data_word(16'h0065));
		// start in the lower slot
		set_entry(12, 1'b1, idle_word(4'hf, 1'b0), start_word(8'd5, 4'ha, 16'h000d));
		set_entry(13, 1'b1, data_word(16'h000d), data_word(16'h000e));
		set_entry(14, 1'b1, idle_word(4'h8, 1'b1), data_word(16'h000f));
		set_entry(15, 1'b1, start_word(8'd3, 4'h0, 16'h0010), data_word(16'h0010));
		set_entry(16, 1'b1, data_word(16'h0011), idle_word(4'h3, 1'b0));
		// short burst, start and stop in one pair
		set_entry(17, 1'b1, start_word(8'd5, 4'h2, 16'h0012), idle_word(4'h0, 1'b0));
	endtask

	////////////////////////////////////////////////////////////
	// reference model of the channel filter
	////////////////////////////////////////////////////////////

	task automatic build_model(input logic [7:0] sel);
		ilk_word_t w;
		logic      mine;
		logic      eop_info;
		logic      start;
		logic      stop;
		mine = 1'b0;
		exp_list = {};
		exp_words = 0;
		exp_bursts = 0;
		for (int i = 0; i < TBL_N; i++) begin
			if (tbl_valid[i]) begin
				// upper word is the first arrival
				for (int k = `ILK_WORDS - 1; k >= 0; k--) begin
					w = tbl_words[i][k];
					eop_info = w[`ILK_CTL_BIT] & w[`ILK_BURST_BIT];
					start = eop_info && w[`ILK_SOP_BIT] &&
						(w[`ILK_CHAN_HI:`ILK_CHAN_LO] == sel);
					stop = eop_info && !start;
					if (start || mine) begin
						// stop keeps its eop, loses the sop of the next channel
						if (stop)
							w[`ILK_SOP_FIELD_BIT] = 1'b0;
						// an opener's eop closes someone else's packet
						if (start && !mine)
							w[`ILK_EOP_HI:`ILK_EOP_LO] = '0;
						exp_list.push_back(w);
						exp_words++;
						if (w[`ILK_CTL_BIT] && w[`ILK_BURST_BIT] && w[`ILK_SOP_BIT])
							exp_bursts++;
						mine = !stop;
					end
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// wishbone master and stream drivers
	////////////////////////////////////////////////////////////

	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		n = 0;
		// ack is looked at mid cycle
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < WB_LIMIT);
		rdata = wb_dat_r;
		assert (wb_ack) else begin
			$display("wishbone access to register %0d got no ack", adr);
			errors++;
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'h0, data);
	endtask

	task automatic expect_reg(input logic [1:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		read_reg(adr, got);
		assert (got == exp) else begin
			$display("error wb_dat_r %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic apply_table();
		for (int i = 0; i < TBL_N; i++) begin
			@(posedge clk);
			in_valid <= tbl_valid[i];
			in_words <= tbl_words[i];
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// wait for the monitor to reach target, then make sure nothing extra shows up
	task automatic wait_drain(input int target);
		int n;
		n = 0;
		while (got_cnt < target && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		repeat (8) @(posedge clk);
		assert (got_cnt == target) else begin
			$display("error out_word count expected %h got %h", target, got_cnt);
			errors++;
		end
	endtask

	// ready pattern, changed by the main process through ready_mode
	always @(posedge clk) begin
		rnd_bits = $urandom;
		case (ready_mode)
			RDY_LOW:  out_ready <= 1'b0;
			RDY_HIGH: out_ready <= 1'b1;
			default:  out_ready <= rnd_bits[0];
		endcase
	end

	////////////////////////////////////////////////////////////
	// output monitor and scoreboard
	////////////////////////////////////////////////////////////

	// a word transfers on the edge after valid and ready are seen here
	always @(negedge clk) begin
		if (!arst && out_valid)
			valid_cycles++;
		if (!arst && check_out && out_valid && out_ready) begin
			exp_w = exp_list[got_cnt % exp_list.size()];
			assert (out_word == exp_w) else begin
				$display("error out_word #%0d expected %h got %h", got_cnt, exp_w, out_word);
				mon_errors++;
			end
			got_cnt++;
		end
	end

	initial begin
		#(WATCHDOG_T);
		$display("watchdog expired before all tests completed");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int          n;
		int          target;
		int          base_valid;
		logic [31:0] rd;
		void'($urandom(98960));
		arst <= 1'b1;
		in_valid <= 1'b0;
		in_words <= '0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_dat_w <= '0;
		build_table();
		build_model(8'd5);
		repeat (10) @(posedge clk);
		arst <= 1'b0;
		@(posedge clk);

		// reset values, then ctrl write and readback
		expect_reg(REG_CTRL, 32'h0, "REG_CTRL");
		expect_reg(REG_WORDS, 32'h0, "REG_WORDS");
		expect_reg(REG_BURSTS, 32'h0, "REG_BURSTS");
		expect_reg(REG_STATUS, 32'h2, "REG_STATUS");
		write_reg(REG_CTRL, CTRL_CH5_ON);
		expect_reg(REG_CTRL, CTRL_CH5_ON, "REG_CTRL");

		// disabled filter lets nothing through
		write_reg(REG_CTRL, CTRL_CH5_OFF);
		ready_mode <= RDY_HIGH;
		base_valid = valid_cycles;
		apply_table();
		repeat (12) @(posedge clk);
		assert (valid_cycles == base_valid) else begin
			$display("out_valid went high while the filter was disabled");
			errors++;
		end
		expect_reg(REG_WORDS, 32'h0, "REG_WORDS");

		// channel 5 with ready held high
		write_reg(REG_CTRL, CTRL_CH5_ON);
		check_out = 1'b1;
		target = got_cnt + exp_list.size();
		apply_table();
		wait_drain(target);
		expect_reg(REG_WORDS, 32'(exp_words), "REG_WORDS");
		expect_reg(REG_BURSTS, 32'(exp_bursts), "REG_BURSTS");
		write_reg(REG_WORDS, 32'h0);
		write_reg(REG_BURSTS, 32'h0);
		expect_reg(REG_WORDS, 32'h0, "REG_WORDS");
		expect_reg(REG_BURSTS, 32'h0, "REG_BURSTS");

		// same traffic under random back-pressure
		ready_mode <= RDY_RAND;
		target = got_cnt + exp_list.size();
		apply_table();
		wait_drain(target);
		expect_reg(REG_WORDS, 32'(exp_words), "REG_WORDS");
		expect_reg(REG_BURSTS, 32'(exp_bursts), "REG_BURSTS");
		write_reg(REG_WORDS, 32'h0);
		write_reg(REG_BURSTS, 32'h0);

		// 18 words into a 16 deep fifo with ready low
		ready_mode <= RDY_LOW;
		check_out = 1'b0;
		apply_table();
		repeat (12) @(posedge clk);
		read_reg(REG_STATUS, rd);
		assert (rd[`ILK_STAT_OVF_BIT] == 1'b1) else begin
			$display("error wb_dat_r REG_STATUS bit 0 expected %h got %h", 1'b1, rd[0]);
			errors++;
		end
		// counters see the filter output, dropped words included
		expect_reg(REG_WORDS, 32'(exp_words), "REG_WORDS");
		write_reg(REG_STATUS, 32'h1);
		read_reg(REG_STATUS, rd);
		assert (rd[`ILK_STAT_OVF_BIT] == 1'b0) else begin
			$display("error wb_dat_r REG_STATUS bit 0 expected %h got %h", 1'b0, rd[0]);
			errors++;
		end

		// throw away what is left in the fifo
		ready_mode <= RDY_HIGH;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (out_valid && n < DRAIN_LIMIT);
		assert (!out_valid) else begin
			$display("fifo did not drain after ready was raised");
			errors++;
		end
		@(posedge clk);
		expect_reg(REG_STATUS, 32'h2, "REG_STATUS");
		write_reg(REG_WORDS, 32'h0);
		expect_reg(REG_WORDS, 32'h0, "REG_WORDS");

		$display("%0d errors in register checks, %0d errors on out_word", errors, mon_errors);
		if (errors + mon_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/ilk_pkg.sv
logic/ilk_chan_filter.sv
logic/ilk_word_fifo.sv
logic/ilk_burst_stats.sv
logic/ilk_rx_ctrl.sv
logic/ilk_rx_chan_top.sv
test/tb_ilk_rx_chan.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the interlaken rx channel testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sources.f \
	--top-module tb_ilk_rx_chan \
	--Mdir obj_dir \
	-o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# the testbench prints its verdict on a line of its own
if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1
